//--- hdl/acc_instance.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module acc_instance (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              iob_avalid_i,
   input  logic [`ACC_ADDR_W-1:0]            iob_addr_i,
   input  logic [`ACC_DATA_W-1:0]            iob_wdata_i,
   input  logic [`ACC_DATA_W/8-1:0]          iob_wstrb_i,
   output logic                              iob_rvalid_o,
   output logic [`ACC_DATA_W-1:0]            iob_rdata_o,
   output logic [`ACC_N_RD-1:0]              rd_valid_o,
   output acc_pkg::mem_req_t [`ACC_N_RD-1:0] rd_req_o,
   input  logic [`ACC_N_RD-1:0]              rd_beat_i,
   input  logic [`ACC_N_RD-1:0]              rd_last_i,
   input  logic [`ACC_DATA_W-1:0]            rd_data_i,
   output logic                              m_wvalid_o,
   output acc_pkg::mem_req_t                 m_wreq_o,
   output logic [`ACC_DATA_W-1:0]            m_wdata_o,
   input  logic                              m_wready_i,
   input  logic                              m_wlast_i
);

   localparam int IDX_W = $clog2(`ACC_MAX_LEN);

   typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_t;

   state_t                    state_q;
   logic                      done_q;
   logic                      busy;
   logic                      wr_en;
   logic                      start;
   logic                      wr_go;
   logic                      wr_done;
   logic [2:0]                reg_idx;
   logic [`ACC_DATA_W-1:0]    src_a_q, src_b_q, dst_q, len_q, addend_q;
   logic [`ACC_DATA_W-1:0]    rd_mux;
   acc_pkg::acc_cfg_t         cfg;
   logic                      full_a, full_b;
   logic [IDX_W-1:0]          buf_idx;
   logic [`ACC_DATA_W-1:0]    a_word, b_word;

   // merge the enabled byte lanes into a register value
   function automatic logic [`ACC_DATA_W-1:0] put_bytes(
      input logic [`ACC_DATA_W-1:0]   old_v,
      input logic [`ACC_DATA_W-1:0]   new_v,
      input logic [`ACC_DATA_W/8-1:0] strb
   );
      logic [`ACC_DATA_W-1:0] res;
      res = old_v;
      for (int b = 0; b < `ACC_DATA_W/8; b++) begin
         if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
      end
      return res;
   endfunction

   assign reg_idx = iob_addr_i[4:2];
   assign wr_en   = iob_avalid_i && (|iob_wstrb_i);
   assign busy    = (state_q != ST_IDLE);
   // start only from idle, needs byte lane 0
   assign start   = wr_en && (reg_idx == `ACC_REG_CTRL) && iob_wstrb_i[0] &&
                    iob_wdata_i[0] && !busy;
   assign wr_go   = (state_q == ST_READ) && full_a && full_b;

   assign cfg.src_a  = src_a_q[`ACC_MEM_ADDR_W-1:0];
   assign cfg.src_b  = src_b_q[`ACC_MEM_ADDR_W-1:0];
   assign cfg.dst    = dst_q[`ACC_MEM_ADDR_W-1:0];
   assign cfg.len    = len_q[`ACC_LEN_W-1:0];
   assign cfg.addend = addend_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         src_a_q  <= '0;
         src_b_q  <= '0;
         dst_q    <= '0;
         len_q    <= '0;
         addend_q <= '0;
      end else if (wr_en) begin
         case (reg_idx)
            `ACC_REG_SRC_A:  src_a_q  <= put_bytes(src_a_q, iob_wdata_i, iob_wstrb_i);
            `ACC_REG_SRC_B:  src_b_q  <= put_bytes(src_b_q, iob_wdata_i, iob_wstrb_i);
            `ACC_REG_DST:    dst_q    <= put_bytes(dst_q, iob_wdata_i, iob_wstrb_i);
            `ACC_REG_LEN:    len_q    <= put_bytes(len_q, iob_wdata_i, iob_wstrb_i);
            `ACC_REG_ADDEND: addend_q <= put_bytes(addend_q, iob_wdata_i, iob_wstrb_i);
            default: ;
         endcase
      end
   end

   always_comb begin
      case (reg_idx)
         `ACC_REG_STATUS: rd_mux = {{(`ACC_DATA_W-2){1'b0}}, done_q, busy};
         `ACC_REG_SRC_A:  rd_mux = src_a_q;
         `ACC_REG_SRC_B:  rd_mux = src_b_q;
         `ACC_REG_DST:    rd_mux = dst_q;
         `ACC_REG_LEN:    rd_mux = len_q;
         `ACC_REG_ADDEND: rd_mux = addend_q;
         default:         rd_mux = '0;
      endcase
   end

   // read response one cycle after the request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) iob_rvalid_o <= 1'b0;
      else          iob_rvalid_o <= iob_avalid_i && !(|iob_wstrb_i);
   end

   always_ff @(posedge clk_i) begin
      iob_rdata_o <= rd_mux;
   end

   // run control
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         done_q  <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: if (start) begin
               state_q <= ST_READ;
               done_q  <= 1'b0;
            end
            ST_READ: if (wr_go) state_q <= ST_WRITE;
            ST_WRITE: if (wr_done) begin
               state_q <= ST_IDLE;
               done_q  <= 1'b1;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   acc_vread u_vread_a (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .go_i        (start),
      .base_i      (cfg.src_a),
      .len_i       (cfg.len),
      .req_valid_o (rd_valid_o[0]),
      .req_o       (rd_req_o[0]),
      .beat_i      (rd_beat_i[0]),
      .last_i      (rd_last_i[0]),
      .data_i      (rd_data_i),
      .full_o      (full_a),
      .buf_idx_i   (buf_idx),
      .buf_word_o  (a_word)
   );

   acc_vread u_vread_b (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .go_i        (start),
      .base_i      (cfg.src_b),
      .len_i       (cfg.len),
      .req_valid_o (rd_valid_o[1]),
      .req_o       (rd_req_o[1]),
      .beat_i      (rd_beat_i[1]),
      .last_i      (rd_last_i[1]),
      .data_i      (rd_data_i),
      .full_o      (full_b),
      .buf_idx_i   (buf_idx),
      .buf_word_o  (b_word)
   );

   acc_vwrite u_vwrite (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .go_i      (wr_go),
      .cfg_i     (cfg),
      .buf_idx_o (buf_idx),
      .a_word_i  (a_word),
      .b_word_i  (b_word),
      .wvalid_o  (m_wvalid_o),
      .wreq_o    (m_wreq_o),
      .wdata_o   (m_wdata_o),
      .wready_i  (m_wready_i),
      .wlast_i   (m_wlast_i),
      .done_o    (wr_done)
   );

endmodule

//--- hdl/acc_merge.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module acc_merge #(
   parameter int N_SLAVES = `ACC_N_RD
) (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic [N_SLAVES-1:0]               s_valid_i,
   input  acc_pkg::mem_req_t [N_SLAVES-1:0]  s_req_i,
   output logic [N_SLAVES-1:0]               s_beat_o,
   output logic [N_SLAVES-1:0]               s_last_o,
   output logic                              m_valid_o,
   output acc_pkg::mem_req_t                 m_req_o,
   input  logic                              m_ready_i,
   input  logic                              m_last_i
);

   localparam int IDX_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic             locked_q;
   logic [IDX_W-1:0] gnt_q;
   logic [IDX_W-1:0] ptr_q;
   logic             found;
   logic [IDX_W-1:0] sel;

   // first requester at or after the pointer
   always_comb begin
      int cand;
      found = 1'b0;
      sel   = '0;
      for (int k = 0; k < N_SLAVES; k++) begin
         cand = (int'(ptr_q) + k) % N_SLAVES;
         if (!found && s_valid_i[cand]) begin
            found = 1'b1;
            sel   = IDX_W'(cand);
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         locked_q <= 1'b0;
         gnt_q    <= '0;
         ptr_q    <= '0;
      end else if (!locked_q) begin
         if (found) begin
            locked_q <= 1'b1;
            gnt_q    <= sel;
            ptr_q    <= IDX_W'((int'(sel) + 1) % N_SLAVES);
         end
      end else if (m_ready_i && m_last_i) begin
         // burst over, rearbitrate next cycle
         locked_q <= 1'b0;
      end
   end

   assign m_valid_o = locked_q && s_valid_i[gnt_q];
   assign m_req_o   = s_req_i[gnt_q];

   // only the granted reader sees the beats
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_beat_o[i] = locked_q && (gnt_q == IDX_W'(i)) && m_ready_i;
         s_last_o[i] = locked_q && (gnt_q == IDX_W'(i)) && m_ready_i && m_last_i;
      end
   end

endmodule

//--- hdl/acc_params.svh
`ifndef ACC_PARAMS_SVH
`define ACC_PARAMS_SVH

// datapath and bus widths
`define ACC_DATA_W      32
`define ACC_ADDR_W      8
`define ACC_MEM_ADDR_W  16
`define ACC_LEN_W       5

// local buffer depth, also the longest burst
`define ACC_MAX_LEN     16
`define ACC_N_RD        2

// register word index, host addr bits 4..2
`define ACC_REG_CTRL    3'd0
`define ACC_REG_STATUS  3'd1
`define ACC_REG_SRC_A   3'd2
`define ACC_REG_SRC_B   3'd3
`define ACC_REG_DST     3'd4
`define ACC_REG_LEN     3'd5
`define ACC_REG_ADDEND  3'd6

`endif

//--- hdl/acc_pkg.sv
`include "acc_params.svh"

package acc_pkg;

   // one burst request on the memory bus
   typedef struct packed {
      logic [`ACC_MEM_ADDR_W-1:0] addr;
      logic [`ACC_LEN_W-1:0]      len;
   } mem_req_t;

   // run configuration as seen by the io units
   typedef struct packed {
      logic [`ACC_MEM_ADDR_W-1:0] src_a;
      logic [`ACC_MEM_ADDR_W-1:0] src_b;
      logic [`ACC_MEM_ADDR_W-1:0] dst;
      logic [`ACC_LEN_W-1:0]      len;
      logic [`ACC_DATA_W-1:0]     addend;
   } acc_cfg_t;

endpackage

//--- hdl/acc_vread.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module acc_vread (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  go_i,
   input  logic [`ACC_MEM_ADDR_W-1:0]            base_i,
   input  logic [`ACC_LEN_W-1:0]                 len_i,
   output logic                                  req_valid_o,
   output acc_pkg::mem_req_t                     req_o,
   input  logic                                  beat_i,
   input  logic                                  last_i,
   input  logic [`ACC_DATA_W-1:0]                data_i,
   output logic                                  full_o,
   input  logic [$clog2(`ACC_MAX_LEN)-1:0]       buf_idx_i,
   output logic [`ACC_DATA_W-1:0]                buf_word_o
);

   localparam int IDX_W = $clog2(`ACC_MAX_LEN);

   logic [`ACC_DATA_W-1:0] buf_mem [`ACC_MAX_LEN];
   logic [IDX_W-1:0]       wr_idx_q;

   // burst request is taken from the config at go
   always_ff @(posedge clk_i) begin
      if (go_i) begin
         req_o.addr <= base_i;
         req_o.len  <= len_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_valid_o <= 1'b0;
         full_o      <= 1'b0;
         wr_idx_q    <= '0;
      end else if (go_i) begin
         req_valid_o <= 1'b1;
         full_o      <= 1'b0;
         wr_idx_q    <= '0;
      end else if (beat_i) begin
         wr_idx_q <= wr_idx_q + 1'b1;
         // hold full until the next run
         if (last_i) begin
            req_valid_o <= 1'b0;
            full_o      <= 1'b1;
         end
      end
   end

   // buffer fill, one word per beat
   always_ff @(posedge clk_i) begin
      if (beat_i) buf_mem[wr_idx_q] <= data_i;
   end

   // writer reads the buffer without a cycle of delay
   assign buf_word_o = buf_mem[buf_idx_i];

endmodule

//--- hdl/acc_vwrite.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module acc_vwrite (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  go_i,
   input  acc_pkg::acc_cfg_t                     cfg_i,
   output logic [$clog2(`ACC_MAX_LEN)-1:0]       buf_idx_o,
   input  logic [`ACC_DATA_W-1:0]                a_word_i,
   input  logic [`ACC_DATA_W-1:0]                b_word_i,
   output logic                                  wvalid_o,
   output acc_pkg::mem_req_t                     wreq_o,
   output logic [`ACC_DATA_W-1:0]                wdata_o,
   input  logic                                  wready_i,
   input  logic                                  wlast_i,
   output logic                                  done_o
);

   localparam int IDX_W = $clog2(`ACC_MAX_LEN);

   logic [IDX_W-1:0]       idx_q;
   logic [`ACC_DATA_W-1:0] addend_q;
   logic                   accept;

   // latched at go so a host write mid-run has no effect
   always_ff @(posedge clk_i) begin
      if (go_i) begin
         wreq_o.addr <= cfg_i.dst;
         wreq_o.len  <= cfg_i.len;
         addend_q    <= cfg_i.addend;
      end
   end

   assign accept = wvalid_o && wready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wvalid_o <= 1'b0;
         idx_q    <= '0;
      end else if (go_i) begin
         wvalid_o <= 1'b1;
         idx_q    <= '0;
      end else if (accept) begin
         idx_q <= idx_q + 1'b1;
         if (wlast_i) wvalid_o <= 1'b0;
      end
   end

   assign buf_idx_o = idx_q;

   // sum wraps modulo 2^32, stable while idx holds
   assign wdata_o = a_word_i + b_word_i + addend_q;

   // final beat accepted, status updates on the next edge
   assign done_o = accept && wlast_i;

endmodule

//--- hdl/iob_acc.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module iob_acc (
   input  logic                        clk_i,
   input  logic                        rst_n_i,

   // host side, native iob
   input  logic                        iob_avalid_i,
   input  logic [`ACC_ADDR_W-1:0]      iob_addr_i,
   input  logic [`ACC_DATA_W-1:0]      iob_wdata_i,
   input  logic [`ACC_DATA_W/8-1:0]    iob_wstrb_i,
   output logic                        iob_rvalid_o,
   output logic [`ACC_DATA_W-1:0]      iob_rdata_o,
   output logic                        iob_ready_o,

   // memory read channel
   output logic                        m_rvalid_o,
   output acc_pkg::mem_req_t           m_rreq_o,
   input  logic                        m_rready_i,
   input  logic [`ACC_DATA_W-1:0]      m_rdata_i,
   input  logic                        m_rlast_i,

   // memory write channel
   output logic                        m_wvalid_o,
   output acc_pkg::mem_req_t           m_wreq_o,
   output logic [`ACC_DATA_W-1:0]      m_wdata_o,
   input  logic                        m_wready_i,
   input  logic                        m_wlast_i
);

   logic [`ACC_N_RD-1:0]                    rd_valid;
   acc_pkg::mem_req_t [`ACC_N_RD-1:0]       rd_req;
   logic [`ACC_N_RD-1:0]                    rd_beat;
   logic [`ACC_N_RD-1:0]                    rd_last;

   // host never stalls
   assign iob_ready_o = 1'b1;

   acc_instance u_instance (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .iob_avalid_i (iob_avalid_i),
      .iob_addr_i   (iob_addr_i),
      .iob_wdata_i  (iob_wdata_i),
      .iob_wstrb_i  (iob_wstrb_i),
      .iob_rvalid_o (iob_rvalid_o),
      .iob_rdata_o  (iob_rdata_o),
      .rd_valid_o   (rd_valid),
      .rd_req_o     (rd_req),
      .rd_beat_i    (rd_beat),
      .rd_last_i    (rd_last),
      .rd_data_i    (m_rdata_i),
      .m_wvalid_o   (m_wvalid_o),
      .m_wreq_o     (m_wreq_o),
      .m_wdata_o    (m_wdata_o),
      .m_wready_i   (m_wready_i),
      .m_wlast_i    (m_wlast_i)
   );

   // the two readers share one read channel
   acc_merge #(
      .N_SLAVES (`ACC_N_RD)
   ) u_merge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .s_valid_i (rd_valid),
      .s_req_i   (rd_req),
      .s_beat_o  (rd_beat),
      .s_last_o  (rd_last),
      .m_valid_o (m_rvalid_o),
      .m_req_o   (m_rreq_o),
      .m_ready_i (m_rready_i),
      .m_last_i  (m_rlast_i)
   );

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_iob_acc -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log \
   && grep -q "^TEST PASS$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+hdl
hdl/acc_pkg.sv
hdl/acc_merge.sv
hdl/acc_vread.sv
hdl/acc_vwrite.sv
hdl/acc_instance.sv
hdl/iob_acc.sv
tb/acc_properties.sv
tb/tb_iob_acc.sv

//--- tb/acc_properties.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module acc_properties (
   input logic                     clk_i,
   input logic                     rst_n_i,
   input logic                     iob_avalid_i,
   input logic [`ACC_DATA_W/8-1:0] iob_wstrb_i,
   input logic                     iob_rvalid_o,
   input logic                     m_rvalid_o,
   input logic                     m_rready_i,
   input logic                     m_rlast_i,
   input logic                     m_wvalid_o,
   input logic                     m_wready_i,
   input logic [`ACC_DATA_W-1:0]   m_wdata_o
);

   // read request held until its last beat
   rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_rvalid_o && !(m_rready_i && m_rlast_i) |=> m_rvalid_o)
      else $error("m_rvalid_o dropped before m_rlast_i");

   wdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o))
      else $error("m_wdata_o changed while stalled");

   // one cycle read response
   rvalid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_avalid_i && (iob_wstrb_i == '0) |=> iob_rvalid_o)
      else $error("iob_rvalid_o missing after a read request");

endmodule

//--- tb/tb_iob_acc.sv
`timescale 1ns/1ps

`include "acc_params.svh"

module tb_iob_acc;

   localparam int N_RUNS     = 20;
   localparam int RUN_CYCLES = 400;
   localparam int LIMIT      = N_RUNS * RUN_CYCLES;
   localparam int MEM_WORDS  = 1024;

   logic                        clk_i = 1'b0;
   logic                        rst_n_i;
   logic                        iob_avalid_i;
   logic [`ACC_ADDR_W-1:0]      iob_addr_i;
   logic [`ACC_DATA_W-1:0]      iob_wdata_i;
   logic [`ACC_DATA_W/8-1:0]    iob_wstrb_i;
   logic                        iob_rvalid_o;
   logic [`ACC_DATA_W-1:0]      iob_rdata_o;
   logic                        iob_ready_o;
   logic                        m_rvalid_o;
   acc_pkg::mem_req_t           m_rreq_o;
   logic                        m_rready_i;
   logic [`ACC_DATA_W-1:0]      m_rdata_i;
   logic                        m_rlast_i;
   logic                        m_wvalid_o;
   acc_pkg::mem_req_t           m_wreq_o;
   logic [`ACC_DATA_W-1:0]      m_wdata_o;
   logic                        m_wready_i;
   logic                        m_wlast_i;

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] exp_mem [MEM_WORDS];
   logic [15:0] lfsr = 16'd92;
   int          err_cnt = 0;
   int          other_cnt = 0;
   int          cycles = 0;
   logic [15:0] rd_log_addr [$];
   logic [4:0]  rd_log_len [$];
   // memory model burst state
   logic        ractive = 1'b0;
   logic        wactive = 1'b0;
   logic [15:0] raddr, waddr;
   int          rlen, wlen, rcnt, wcnt;

   always #50 clk_i = ~clk_i;

   iob_acc u_iob_acc (.*);

   bind iob_acc acc_properties u_props (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .iob_avalid_i (iob_avalid_i),
      .iob_wstrb_i  (iob_wstrb_i),
      .iob_rvalid_o (iob_rvalid_o),
      .m_rvalid_o   (m_rvalid_o),
      .m_rready_i   (m_rready_i),
      .m_rlast_i    (m_rlast_i),
      .m_wvalid_o   (m_wvalid_o),
      .m_wready_i   (m_wready_i),
      .m_wdata_o    (m_wdata_o)
   );

   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic next_bit();
      logic b;
      b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], b};
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
      return v;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic host_write(input logic [2:0] idx, input logic [31:0] data, input logic [3:0] strb);
      @(posedge clk_i);
      iob_avalid_i <= 1'b1;
      iob_addr_i   <= {3'b000, idx, 2'b00};
      iob_wdata_i  <= data;
      iob_wstrb_i  <= strb;
      @(posedge clk_i);
      iob_avalid_i <= 1'b0;
      iob_wstrb_i  <= 4'h0;
   endtask

   task automatic host_read(input logic [2:0] idx, output logic [31:0] data);
      @(posedge clk_i);
      iob_avalid_i <= 1'b1;
      iob_addr_i   <= {3'b000, idx, 2'b00};
      iob_wstrb_i  <= 4'h0;
      @(posedge clk_i);
      iob_avalid_i <= 1'b0;
      @(negedge clk_i);
      data = iob_rdata_o;
      if (!iob_rvalid_o) begin
         $display("read response missing for register %0d", idx);
         other_cnt++;
      end
      check("iob_ready_o", 32'(iob_ready_o), 32'h1);
   endtask

   // full write and a partial write with random lanes before readback
   task automatic check_register(input logic [2:0] idx, input string name);
      logic [31:0] first;
      logic [31:0] second;
      logic [3:0]  strb;
      logic [31:0] mask;
      logic [31:0] got;
      first  = rand_bits(32);
      second = rand_bits(32);
      strb   = 4'(rand_bits(4));
      // enabled lanes take the second value
      mask   = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      host_write(idx, first, 4'hf);
      host_write(idx, second, strb);
      host_read(idx, got);
      check(name, got, (first & ~mask) | (second & mask));
   endtask

   task automatic do_run(input int run_no);
      logic [15:0] src_a, src_b, dst;
      logic [31:0] addend;
      logic [31:0] st;
      int          len;
      int          seen_a;
      int          seen_b;
      len    = (run_no == 0) ? 1 : (run_no == 1) ? 16 : int'(rand_bits(4)) + 1;
      src_a  = 16'(rand_bits(7));
      src_b  = 16'(32'd256 + rand_bits(7));
      dst    = 16'(32'd512 + rand_bits(8));
      addend = rand_bits(32);
      check_register(`ACC_REG_SRC_A, "src_a");
      check_register(`ACC_REG_SRC_B, "src_b");
      check_register(`ACC_REG_DST, "dst");
      check_register(`ACC_REG_LEN, "len");
      check_register(`ACC_REG_ADDEND, "addend");
      host_write(`ACC_REG_SRC_A, 32'(src_a), 4'hf);
      host_write(`ACC_REG_SRC_B, 32'(src_b), 4'hf);
      host_write(`ACC_REG_DST, 32'(dst), 4'hf);
      host_write(`ACC_REG_LEN, 32'(len), 4'hf);
      host_write(`ACC_REG_ADDEND, addend, 4'hf);
      // expected image from the model memory before the run
      for (int i = 0; i < MEM_WORDS; i++) exp_mem[i] = mem[i];
      for (int i = 0; i < len; i++) begin
         exp_mem[dst + i] = mem[src_a + i] + mem[src_b + i] + addend;
      end
      rd_log_addr.delete();
      rd_log_len.delete();
      host_write(`ACC_REG_CTRL, 32'h1, 4'hf);
      host_read(`ACC_REG_STATUS, st);
      check("status_busy", st, 32'h1);
      // ignored while busy
      host_write(`ACC_REG_CTRL, 32'h1, 4'hf);
      do host_read(`ACC_REG_STATUS, st); while (st[0]);
      check("status_done", st, 32'h2);
      for (int i = 0; i < MEM_WORDS; i++) check($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
      check("rd_req_count", rd_log_addr.size(), 2);
      seen_a = 0;
      seen_b = 0;
      foreach (rd_log_addr[k]) begin
         if (rd_log_addr[k] == src_a) seen_a++;
         if (rd_log_addr[k] == src_b) seen_b++;
         check("rd_req_len", 32'(rd_log_len[k]), 32'(len));
      end
      check("rd_req_src_a", seen_a, 1);
      check("rd_req_src_b", seen_b, 1);
   endtask

   // memory model consumes a beat on the edge where ready was high
   always @(posedge clk_i) begin
      if (rst_n_i) begin
         if (m_rready_i) begin
            rcnt++;
            if (m_rlast_i) ractive = 1'b0;
         end
         if (!ractive && m_rvalid_o && !(m_rready_i && m_rlast_i)) begin
            ractive = 1'b1;
            raddr   = m_rreq_o.addr;
            rlen    = m_rreq_o.len;
            rcnt    = 0;
            rd_log_addr.push_back(m_rreq_o.addr);
            rd_log_len.push_back(m_rreq_o.len);
         end
         m_rready_i <= 1'b0;
         m_rlast_i  <= 1'b0;
         if (ractive && next_bit()) begin
            m_rready_i <= 1'b1;
            m_rdata_i  <= mem[10'(raddr + rcnt)];
            m_rlast_i  <= (rcnt == rlen - 1);
         end
         if (m_wready_i) begin
            mem[10'(waddr + wcnt)] = m_wdata_o;
            wcnt++;
            if (m_wlast_i) wactive = 1'b0;
         end
         if (!wactive && m_wvalid_o && !(m_wready_i && m_wlast_i)) begin
            wactive = 1'b1;
            waddr   = m_wreq_o.addr;
            wlen    = m_wreq_o.len;
            wcnt    = 0;
         end
         m_wready_i <= 1'b0;
         m_wlast_i  <= 1'b0;
         if (wactive && next_bit()) begin
            m_wready_i <= 1'b1;
            m_wlast_i  <= (wcnt == wlen - 1);
         end
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout: the runs did not finish within %0d cycles", LIMIT);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial begin
      rst_n_i      = 1'b0;
      iob_avalid_i = 1'b0;
      iob_addr_i   = '0;
      iob_wdata_i  = '0;
      iob_wstrb_i  = '0;
      m_rready_i   = 1'b0;
      m_rdata_i    = '0;
      m_rlast_i    = 1'b0;
      m_wready_i   = 1'b0;
      m_wlast_i    = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = rand_bits(32);
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (int r = 0; r < N_RUNS; r++) do_run(r);
      $display("errors: %0d mismatches, %0d other failures", err_cnt, other_cnt);
      if (err_cnt == 0 && other_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
